//--- compile.f
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_prefetcher.sv
logic/fetch_buffer.sv
logic/fetch_unit.sv
verif/fetch_mem_model.sv
verif/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it, grade the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=fetch_unit_sim
LOG_FILE=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module fetch_unit_tb \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN" \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG_FILE"
exit 1

//--- verif/fetch_vectors.txt
// Columns: branch target, pointer flag, words to consume, consumer stall percent
// All fields hex; a line with zero words makes the next branch back-to-back
00001000 0 00000010 00
00002000 0 00000018 00
00003000 1 0000000c 0a
// Heavy stalls fill the buffer
00004000 0 00000020 5a
00005000 0 00000006 00
// Flagged branch overridden next cycle
00006000 1 00000000 00
00007000 0 0000000c 14
00008000 0 00000000 00
00009000 1 00000008 00
0000a000 0 00000003 32
0000b000 0 00000028 4b
0000c000 1 00000001 00
// Branch while the previous stream still has responses in flight
0000d000 0 00000002 00
0000e000 0 00000010 1e
0001f000 1 00000005 3c

//--- verif/fetch_unit_tb.sv
//////////////////////////////
// Fetch unit testbench
// Vector reader, consumer driver, bus and in-flight monitors, watchdog
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_unit_tb;

  localparam logic [31:0] DATA_KEY  = 32'hc3a5_9e01;
  localparam int          MAX_TESTS = 32;
  localparam int          WORD_BOUND = 40;

  logic        clk;
  logic        rst_n;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        branch_ptr_i;
  logic        instr_ready_i;
  logic        instr_valid_o;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_o;
  logic        instr_ptr_o;
  logic        bus_req_o;
  logic [31:0] bus_addr_o;
  logic        bus_ptr_o;
  logic        bus_gnt_i;
  logic        bus_rvalid_i;
  logic [31:0] bus_rdata_i;

  // Four hex words per test
  logic [31:0] vec_mem [0:4*MAX_TESTS-1];
  integer      seed;
  int          num_tests;
  int          errors;
  int          checks;
  int          test_errors;
  int          in_flight;
  int unsigned cycle_cnt;
  int unsigned cycle_limit = 1000;

  // Address and pointer flag expected on the next granted request
  logic [31:0] exp_bus_addr;
  logic        exp_bus_ptr;

  fetch_unit dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_ptr_i  (branch_ptr_i),
    .instr_valid_o (instr_valid_o),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_ptr_o   (instr_ptr_o),
    .instr_ready_i (instr_ready_i),
    .bus_req_o     (bus_req_o),
    .bus_addr_o    (bus_addr_o),
    .bus_ptr_o     (bus_ptr_o),
    .bus_gnt_i     (bus_gnt_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i)
  );

  fetch_mem_model #(.DATA_KEY(DATA_KEY), .SEED(32'h042af894)) mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req_o),
    .bus_addr_i   (bus_addr_o),
    .bus_gnt_o    (bus_gnt_i),
    .bus_rvalid_o (bus_rvalid_i),
    .bus_rdata_o  (bus_rdata_i)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  //////////////////////////////
  // Monitors
  //////////////////////////////

  // Granted words of the current stream not yet taken must fit the buffer
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (branch_i)
      begin
        in_flight    = 0;
        exp_bus_addr = branch_addr_i;
        exp_bus_ptr  = branch_ptr_i;
      end
      else
      begin
        if (bus_req_o && bus_gnt_i)
        begin
          // Requests run sequentially from the latest target
          check_value("bus_addr_o", bus_addr_o, exp_bus_addr);
          check_value("bus_ptr_o", 32'(bus_ptr_o), 32'(exp_bus_ptr));
          exp_bus_addr = exp_bus_addr + 32'd4;
          exp_bus_ptr  = 1'b0;
        end
        in_flight = in_flight + int'(bus_req_o && bus_gnt_i)
                    - int'(instr_valid_o && instr_ready_i);
        check_value("words in flight within depth", 32'(in_flight <= `FETCH_DEPTH), 32'd1);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: consumer still waiting for words after %0d cycles", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  // Branch, then consume the given words with random back-pressure
  task automatic fetch_stream(input int idx, input logic [31:0] target, input logic ptr,
                              input int words, input int stall);
    int          taken;
    logic [31:0] exp_addr;
    taken       = 0;
    exp_addr    = target;
    test_errors = 0;
    branch_i      = 1'b1;
    branch_addr_i = target;
    branch_ptr_i  = ptr;
    instr_ready_i = 1'b0;
    @(posedge clk);
    #1;
    branch_i = 1'b0;
    while (taken < words)
    begin
      instr_ready_i = ($unsigned($random(seed)) % 100) >= stall;
      @(negedge clk);
      if (instr_valid_o && instr_ready_i)
      begin
        check_value("instr_addr_o", instr_addr_o, exp_addr);
        check_value("instr_rdata_o", instr_rdata_o, exp_addr ^ DATA_KEY);
        check_value("instr_ptr_o", 32'(instr_ptr_o), 32'((taken == 0) && ptr));
        taken++;
        exp_addr = exp_addr + 32'd4;
      end
      @(posedge clk);
      #1;
    end
    instr_ready_i = 1'b0;
    $display("Test %0d target %h ptr %0d words %0d stall %0d%%: %s", idx, target, ptr,
             words, stall, (test_errors == 0) ? "ok" : "mismatch");
  endtask

  initial
  begin
    int total_words;
    seed          = 32'h042af894;
    clk           = 1'b0;
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    branch_ptr_i  = 1'b0;
    instr_ready_i = 1'b0;
    errors        = 0;
    checks        = 0;
    in_flight     = 0;
    exp_bus_addr  = '0;
    exp_bus_ptr   = 1'b0;
    cycle_cnt     = 0;
    total_words   = 0;
    num_tests     = 0;

    // Unused slots keep an unaligned marker
    for (int i = 0; i < 4*MAX_TESTS; i++)
    begin
      vec_mem[i] = 32'hffff_ffff;
    end
    $readmemh("verif/fetch_vectors.txt", vec_mem);
    while ((num_tests < MAX_TESTS) && (vec_mem[4*num_tests] != 32'hffff_ffff))
    begin
      total_words = total_words + int'(vec_mem[4*num_tests+2]);
      num_tests++;
    end
    cycle_limit = total_words * WORD_BOUND + num_tests * WORD_BOUND + 200;

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // Nothing moves before the first branch
    test_errors = 0;
    repeat (6)
    begin
      @(negedge clk);
      check_value("bus_req_o before branch", 32'(bus_req_o), 32'd0);
      check_value("instr_valid_o before branch", 32'(instr_valid_o), 32'd0);
    end
    $display("Test 0 idle after reset: %s", (test_errors == 0) ? "ok" : "mismatch");
    @(posedge clk);
    #1;

    for (int t = 0; t < num_tests; t++)
    begin
      fetch_stream(t + 1, vec_mem[4*t], vec_mem[4*t+1][0], int'(vec_mem[4*t+2]),
                   int'(vec_mem[4*t+3]));
    end

    $display("Tests %0d, checks %0d, errors %0d", num_tests + 1, checks, errors);
    if (errors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/fetch_mem_model.sv
//////////////////////////////
// Instruction bus slave model
// Random grant, one-cycle response
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module fetch_mem_model
#(
  parameter logic [31:0] DATA_KEY = 32'h0,
  parameter logic [31:0] SEED     = 32'h1
)
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         bus_req_i,
  input  wire  [31:0] bus_addr_i,
  output logic        bus_gnt_o,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o
);

  integer      seed;
  logic        accept;
  logic [31:0] accept_addr;

  initial
  begin
    seed         = SEED;
    accept       = 1'b0;
    accept_addr  = '0;
    bus_gnt_o    = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_rdata_o  = '0;
  end

  // Request and grant are stable mid-cycle
  always @(negedge clk)
  begin
    accept      = rst_n && bus_req_i && bus_gnt_o;
    accept_addr = bus_addr_i;
  end

  // Response one cycle after the grant, grant about three in four cycles
  always @(posedge clk)
  begin
    #1;
    bus_rvalid_o = accept;
    bus_rdata_o  = accept ? (accept_addr ^ DATA_KEY) : 32'h0;
    bus_gnt_o    = rst_n && (($random(seed) & 3) != 0);
  end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
//////////////////////////////
// Fetch unit top level
// Buffer and prefetcher between consumer and bus
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module fetch_unit
(
  input  wire         clk,
  input  wire         rst_n,

  // Consumer side
  input  wire         branch_i,
  input  wire  [31:0] branch_addr_i,
  input  wire         branch_ptr_i,
  output logic        instr_valid_o,
  output logic [31:0] instr_addr_o,
  output logic [31:0] instr_rdata_o,
  output logic        instr_ptr_o,
  input  wire         instr_ready_i,

  // Instruction bus
  output logic        bus_req_o,
  output logic [31:0] bus_addr_o,
  output logic        bus_ptr_o,
  input  wire         bus_gnt_i,
  input  wire         bus_rvalid_i,
  input  wire  [31:0] bus_rdata_i
);

  // Buffer to prefetcher
  logic        fetch_valid;
  logic        fetch_ready;
  logic        fetch_branch;
  logic [31:0] fetch_branch_addr;
  logic        fetch_branch_ptr;

  //////////////////////////////
  // Buffer
  //////////////////////////////

  fetch_buffer u_buffer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .branch_ptr_i        (branch_ptr_i),
    .fetch_valid_o       (fetch_valid),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .fetch_branch_ptr_o  (fetch_branch_ptr),
    .fetch_ready_i       (fetch_ready),
    // Issued address goes to the tag queue as well
    .trans_addr_i        (bus_addr_o),
    .trans_ptr_i         (bus_ptr_o),
    .resp_valid_i        (bus_rvalid_i),
    .resp_rdata_i        (bus_rdata_i),
    .instr_valid_o       (instr_valid_o),
    .instr_addr_o        (instr_addr_o),
    .instr_rdata_o       (instr_rdata_o),
    .instr_ptr_o         (instr_ptr_o),
    .instr_ready_i       (instr_ready_i)
  );

  //////////////////////////////
  // Prefetcher
  //////////////////////////////

  fetch_prefetcher u_prefetcher (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .fetch_branch_ptr_i  (fetch_branch_ptr),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .trans_valid_o       (bus_req_o),
    .trans_addr_o        (bus_addr_o),
    .trans_ptr_o         (bus_ptr_o),
    .trans_ready_i       (bus_gnt_i)
  );

endmodule

`default_nettype wire

//--- logic/fetch_buffer.sv
//////////////////////////////
// Fetch buffer
// Word FIFO, in-order tag queue, stale response discard
// and the bus request decision
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "fetch_settings.svh"

module fetch_buffer import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,

  // Branch from the consumer
  input  wire         branch_i,
  input  wire  [31:0] branch_addr_i,
  input  wire         branch_ptr_i,

  // To and from the prefetcher
  output logic        fetch_valid_o,
  output logic        fetch_branch_o,
  output logic [31:0] fetch_branch_addr_o,
  output logic        fetch_branch_ptr_o,
  input  wire         fetch_ready_i,
  input  wire  [31:0] trans_addr_i,
  input  wire         trans_ptr_i,

  // Bus responses, in order
  input  wire         resp_valid_i,
  input  wire  [31:0] resp_rdata_i,

  // Words to the consumer
  output logic        instr_valid_o,
  output logic [31:0] instr_addr_o,
  output logic [31:0] instr_rdata_o,
  output logic        instr_ptr_o,
  input  wire         instr_ready_i
);

  localparam int unsigned DEPTH = `FETCH_DEPTH;
  localparam int unsigned CNT_W = `FETCH_CNT_W;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  // Word FIFO storage
  logic [31:0]      fifo_addr [DEPTH];
  logic [31:0]      fifo_data [DEPTH];
  logic             fifo_ptr  [DEPTH];
  logic [PTR_W-1:0] fifo_wr_q;
  logic [PTR_W-1:0] fifo_rd_q;
  logic [CNT_W-1:0] fifo_cnt_q;

  // Tag queue, one entry per outstanding request
  logic [31:0]      tag_addr [DEPTH];
  logic             tag_ptr  [DEPTH];
  logic [PTR_W-1:0] tag_wr_q;
  logic [PTR_W-1:0] tag_rd_q;

  logic [CNT_W-1:0] outst_q;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W:0]   level;
  logic             started_q;
  logic             push;
  logic             pop;

  // Branch bookkeeping, checked against the granted address
  prefetch_state_e  pend_q;
  logic [31:0]      pend_addr_q;

  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = branch_addr_i;
  assign fetch_branch_ptr_o  = branch_ptr_i;

  //////////////////////////////
  // Request decision
  //////////////////////////////

  // Every outstanding request owns a free FIFO slot
  assign level         = outst_q + fifo_cnt_q;
  assign fetch_valid_o = started_q && !branch_i && (level < (CNT_W+1)'(DEPTH));

  // Stale responses and those in a branch cycle are dropped
  assign push = resp_valid_i && (discard_q == '0) && !branch_i;
  assign pop  = instr_valid_o && instr_ready_i;

  assign instr_valid_o = (fifo_cnt_q != '0);
  assign instr_addr_o  = fifo_addr[fifo_rd_q];
  assign instr_rdata_o = fifo_data[fifo_rd_q];
  assign instr_ptr_o   = fifo_ptr[fifo_rd_q];

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      started_q  <= 1'b0;
      fifo_wr_q  <= '0;
      fifo_rd_q  <= '0;
      fifo_cnt_q <= '0;
      tag_wr_q   <= '0;
      tag_rd_q   <= '0;
      outst_q    <= '0;
      discard_q  <= '0;
      pend_q     <= IDLE;
    end
    else
    begin
      if (branch_i)
      begin
        started_q <= 1'b1;
      end

      // Tags pop for every response, kept or not
      if (fetch_ready_i)
      begin
        tag_wr_q <= tag_wr_q + 1'b1;
      end
      if (resp_valid_i)
      begin
        tag_rd_q <= tag_rd_q + 1'b1;
      end
      outst_q <= outst_q + CNT_W'(fetch_ready_i) - CNT_W'(resp_valid_i);

      if (branch_i)
      begin
        // Flush, everything still in flight is stale
        fifo_rd_q  <= fifo_wr_q;
        fifo_cnt_q <= '0;
        discard_q  <= outst_q - CNT_W'(resp_valid_i);
      end
      else
      begin
        if (push)
        begin
          fifo_wr_q <= fifo_wr_q + 1'b1;
        end
        if (pop)
        begin
          fifo_rd_q <= fifo_rd_q + 1'b1;
        end
        fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop);
        if (resp_valid_i && (discard_q != '0))
        begin
          discard_q <= discard_q - 1'b1;
        end
      end

      // Target pending until its first grant
      if (branch_i)
      begin
        pend_q <= BRANCH_WAIT;
      end
      else if (fetch_ready_i)
      begin
        pend_q <= IDLE;
      end
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (fetch_ready_i)
    begin
      tag_addr[tag_wr_q] <= trans_addr_i;
      tag_ptr[tag_wr_q]  <= trans_ptr_i;
    end
    if (push)
    begin
      // Response carries the address it was issued with
      fifo_addr[fifo_wr_q] <= tag_addr[tag_rd_q];
      fifo_data[fifo_wr_q] <= resp_rdata_i;
      fifo_ptr[fifo_wr_q]  <= tag_ptr[tag_rd_q];
    end
    if (branch_i)
    begin
      pend_addr_q <= branch_addr_i;
    end
  end

  // Room check must hold across grant and response timing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    level <= (CNT_W+1)'(DEPTH));

  // Bus returns exactly one response per grant
  a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (outst_q != '0));

  // First grant after a branch goes to the latest target
  a_target_first: assert property (@(posedge clk) disable iff (!rst_n)
    (pend_q == BRANCH_WAIT) && fetch_ready_i |-> (trans_addr_i == pend_addr_q));

endmodule

`default_nettype wire

//--- logic/fetch_prefetcher.sv
//////////////////////////////
// Fetch prefetcher
// Next transaction address FSM with branch replay
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module fetch_prefetcher import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,

  // Control flow from the buffer
  input  wire         fetch_branch_i,
  input  wire  [31:0] fetch_branch_addr_i,
  input  wire         fetch_branch_ptr_i,
  input  wire         fetch_valid_i,
  output logic        fetch_ready_o,

  // Transaction request towards the bus
  output logic        trans_valid_o,
  output logic [31:0] trans_addr_o,
  output logic        trans_ptr_o,
  input  wire         trans_ready_i
);

  prefetch_state_e state_q;
  prefetch_state_e state_d;

  // Last issued or branched address and its pointer flag
  logic [31:0] addr_q;
  logic        ptr_q;
  logic [31:0] addr_incr;

  // Addresses are always word aligned
  assign addr_incr = addr_q + 32'd4;

  // Buffer alone decides when a request may go out
  assign trans_valid_o = fetch_valid_i;

  // Accepted request
  assign fetch_ready_o = trans_valid_o && trans_ready_i;

  //////////////////////////////
  // Address selection
  //////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    trans_addr_o = addr_q;
    trans_ptr_o  = ptr_q;

    case (state_q)
      IDLE:
      begin
        if (fetch_branch_i)
        begin
          // Target shows up in the branch cycle itself
          trans_addr_o = fetch_branch_addr_i;
          trans_ptr_o  = fetch_branch_ptr_i;
          if (!fetch_ready_o)
          begin
            state_d = BRANCH_WAIT;
          end
        end
        else
        begin
          // Sequential words are never pointer accesses
          trans_addr_o = addr_incr;
          trans_ptr_o  = 1'b0;
        end
      end

      BRANCH_WAIT:
      begin
        // Replay held target, a newer branch overrides it
        if (fetch_branch_i)
        begin
          trans_addr_o = fetch_branch_addr_i;
          trans_ptr_o  = fetch_branch_ptr_i;
        end
        if (fetch_ready_o)
        begin
          state_d = IDLE;
        end
      end
    endcase
  end

  //////////////////////////////
  // State and held address
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      addr_q  <= '0;
      ptr_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Capture on branch or on grant
      if (fetch_branch_i || fetch_ready_o)
      begin
        addr_q <= trans_addr_o;
        ptr_q  <= trans_ptr_o;
      end
    end
  end

  // Sequential stepping by four relies on aligned targets
  a_branch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_branch_i |-> (fetch_branch_addr_i[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
//////////////////////////////
// Fetch front end package
// Prefetcher state encoding
//////////////////////////////

`default_nettype none

package fetch_pkg;

  //////////////////////////////
  // Prefetcher states
  //////////////////////////////

  // IDLE presents the branch target or the next sequential word
  // BRANCH_WAIT replays a branch target that was not yet granted
  typedef enum logic [0:0] {
    IDLE        = 1'b0,
    BRANCH_WAIT = 1'b1
  } prefetch_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_settings.svh
//////////////////////////////
// Fetch front end build settings
// Buffer depth and counter width
//////////////////////////////

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Number of FIFO entries
// Also the limit on outstanding plus buffered words
// Must be a power of two (2, 4 or 8)
`define FETCH_DEPTH 4

// Occupancy and outstanding counters
// One bit more than the pointer so a full count fits
`define FETCH_CNT_W ($clog2(`FETCH_DEPTH) + 1)

`endif
